// File: include/afu_macros.svh
`ifndef AFU_MACROS_SVH
`define AFU_MACROS_SVH

// ====================
// Datapath widths
// ====================

// Host line address, counted in whole lines
`define AFU_ADDR_W 32
// One cache line of payload, also the width of an MMIO data word
`define AFU_LINE_W 64
// Line count field of the length register
`define AFU_CNT_W 16
// MMIO register index
`define AFU_MMIO_IDX_W 4

// ====================
// CSR map
// ====================

`define AFU_CSR_DFH 4'd0
`define AFU_CSR_SRC 4'd1
`define AFU_CSR_DST 4'd2
`define AFU_CSR_LEN 4'd3
`define AFU_CSR_CTRL 4'd4
`define AFU_CSR_STATUS 4'd5
`define AFU_CSR_SUM 4'd6

// Constant that software finds in the device feature header
`define AFU_ID 64'h1000_0000_afc0_0c01

// Simulation watchdog, a fixed base plus a budget per copied line
`define AFU_TB_TIMEOUT_BASE 2000
`define AFU_TB_CYCLES_PER_LINE 40

`endif

// File: rtl/afu_copy_ctrl.sv
`timescale 1ns/1ps

module afu_copy_ctrl
(
    input  logic pClk,
    input  logic rst_n,
    input  logic start,
    input  logic len_zero,
    input  logic all_issued,
    input  logic all_acked,
    input  logic c0_almost_full,
    output logic issue_rd,
    output logic busy,
    output logic done
);

    import afu_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // ====================
    // Sequencer
    // ====================

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                // An empty job skips the copy and only reports completion
                if (start)
                    state_nxt = len_zero ? ST_DONE : ST_RUN;
            end
            ST_RUN:
            begin
                // Once every read is out, wait for the writes to land
                if (all_issued)
                    state_nxt = ST_DRAIN;
            end
            ST_DRAIN:
            begin
                if (all_acked)
                    state_nxt = ST_DONE;
            end
            ST_DONE:
            begin
                state_nxt = ST_IDLE;
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge pClk)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // One read per cycle while lines remain and the host has room
    assign issue_rd = (state == ST_RUN) && !all_issued && !c0_almost_full;

    // Busy covers the whole job including the completion cycle
    assign busy = (state != ST_IDLE);

    // Completion lasts exactly the one cycle spent in ST_DONE
    assign done = (state == ST_DONE);

    // ====================
    // Checks
    // ====================

    // A start request only reaches the sequencer while it is idle
    a_start_when_idle: assert property (@(posedge pClk) disable iff (!rst_n)
        start |-> (state == ST_IDLE));

    // The issue count stays at the job length for the whole drain phase
    a_drain_all_issued: assert property (@(posedge pClk) disable iff (!rst_n)
        (state == ST_DRAIN) |-> all_issued);

endmodule

// File: rtl/afu_csr_regs.sv
`timescale 1ns/1ps
`include "afu_macros.svh"

module afu_csr_regs
(
    input  logic                   pClk,
    input  logic                   rst_n,
    input  afu_pkg::mmio_req_t     mmio_in,
    output afu_pkg::mmio_rsp_t     mmio_out,
    input  logic                   busy,
    input  logic                   done,
    input  logic [`AFU_LINE_W-1:0] sum,
    output logic                   start,
    output afu_pkg::copy_cfg_t     cfg
);

    import afu_pkg::*;

    copy_cfg_t              cfg_q;
    logic                   start_q;
    logic                   done_flag;
    logic                   rsp_valid;
    logic [`AFU_LINE_W-1:0] rsp_data;
    logic [`AFU_LINE_W-1:0] rd_data;
    logic                   cfg_locked;
    logic                   ctrl_go;

    // Configuration is frozen from the start pulse until the job returns to idle
    assign cfg_locked = busy || start_q;

    // Start request, bit 0 of the control register
    assign ctrl_go = mmio_in.wr && (mmio_in.idx == CSR_CTRL) && mmio_in.data[0];

    // ====================
    // Register writes
    // ====================

    always_ff @(posedge pClk)
    begin
        if (!rst_n)
        begin
            cfg_q   <= '0;
            start_q <= 1'b0;
        end
        else
        begin
            // A start only counts when the sequencer is idle and none is pending
            start_q <= ctrl_go && !cfg_locked;
            if (mmio_in.wr && !cfg_locked)
            begin
                case (mmio_in.idx)
                    CSR_SRC: cfg_q.src <= mmio_in.data[`AFU_ADDR_W-1:0];
                    CSR_DST: cfg_q.dst <= mmio_in.data[`AFU_ADDR_W-1:0];
                    CSR_LEN: cfg_q.len <= mmio_in.data[`AFU_CNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Done stays visible in the status register until software starts again
    always_ff @(posedge pClk)
    begin
        if (!rst_n)
            done_flag <= 1'b0;
        else if (start_q)
            done_flag <= 1'b0;
        else if (done)
            done_flag <= 1'b1;
    end

    // ====================
    // Register reads
    // ====================

    always_comb
    begin
        case (mmio_in.idx)
            CSR_DFH:    rd_data = `AFU_ID;
            CSR_SRC:    rd_data = {{(`AFU_LINE_W-`AFU_ADDR_W){1'b0}}, cfg_q.src};
            CSR_DST:    rd_data = {{(`AFU_LINE_W-`AFU_ADDR_W){1'b0}}, cfg_q.dst};
            CSR_LEN:    rd_data = {{(`AFU_LINE_W-`AFU_CNT_W){1'b0}}, cfg_q.len};
            CSR_STATUS: rd_data = {{(`AFU_LINE_W-2){1'b0}}, done_flag, busy};
            CSR_SUM:    rd_data = sum;
            // Control is write-only and the rest of the space is unmapped
            default:    rd_data = '0;
        endcase
    end

    // Response valid follows the read strobe by exactly one cycle
    always_ff @(posedge pClk)
    begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= mmio_in.rd;
    end

    // Read data only moves when a read is taken
    always_ff @(posedge pClk)
    begin
        if (mmio_in.rd)
            rsp_data <= rd_data;
    end

    assign mmio_out = '{valid: rsp_valid, data: rsp_data};
    assign start    = start_q;
    assign cfg      = cfg_q;

    // The host issues at most one MMIO access per cycle
    a_mmio_one_op: assert property (@(posedge pClk) disable iff (!rst_n)
        !(mmio_in.wr && mmio_in.rd));

endmodule

// File: rtl/afu_line_counter.sv
`timescale 1ns/1ps
`include "afu_macros.svh"

module afu_line_counter
(
    input  logic                  pClk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`AFU_CNT_W-1:0] len,
    input  logic                  issue_rd,
    input  logic                  rd_rsp_valid,
    input  logic                  wr_ack,
    output logic [`AFU_CNT_W-1:0] rd_idx,
    output logic [`AFU_CNT_W-1:0] wr_idx,
    output logic                  all_issued,
    output logic                  all_acked,
    output logic                  len_zero
);

    // Lines requested, lines returned and writes confirmed by the host
    logic [`AFU_CNT_W-1:0] iss_cnt;
    logic [`AFU_CNT_W-1:0] ret_cnt;
    logic [`AFU_CNT_W-1:0] ack_cnt;

    always_ff @(posedge pClk)
    begin
        if (!rst_n || start)
        begin
            iss_cnt <= '0;
            ret_cnt <= '0;
            ack_cnt <= '0;
        end
        else
        begin
            if (issue_rd)
                iss_cnt <= iss_cnt + 1'b1;
            if (rd_rsp_valid)
                ret_cnt <= ret_cnt + 1'b1;
            if (wr_ack)
                ack_cnt <= ack_cnt + 1'b1;
        end
    end

    // Responses come back in order, so the return count is the write index
    assign rd_idx     = iss_cnt;
    assign wr_idx     = ret_cnt;
    assign all_issued = (iss_cnt == len);
    assign all_acked  = (ack_cnt == len);
    assign len_zero   = (len == '0);

    // Nothing is acknowledged before it is returned, nothing returns unasked
    a_cnt_order: assert property (@(posedge pClk) disable iff (!rst_n)
        (ack_cnt <= ret_cnt) && (ret_cnt <= iss_cnt));

endmodule

// File: rtl/afu_line_datapath.sv
`timescale 1ns/1ps
`include "afu_macros.svh"

module afu_line_datapath
(
    input  logic                   pClk,
    input  logic                   rst_n,
    input  logic                   start,
    input  afu_pkg::copy_cfg_t     cfg,
    input  logic                   issue_rd,
    input  logic [`AFU_CNT_W-1:0]  rd_idx,
    input  logic [`AFU_CNT_W-1:0]  wr_idx,
    input  afu_pkg::rd_rsp_t       c0_rsp,
    output afu_pkg::rd_req_t       c0_req,
    output afu_pkg::wr_req_t       c1_req,
    output logic [`AFU_LINE_W-1:0] sum
);

    logic                   rd_valid;
    logic [`AFU_ADDR_W-1:0] rd_addr;
    logic                   wr_valid;
    logic [`AFU_ADDR_W-1:0] wr_addr;
    logic [`AFU_LINE_W-1:0] wr_data;
    logic [`AFU_LINE_W-1:0] sum_q;

    // ====================
    // Request registers
    // ====================

    // Strobes are the only reset state on the host channels
    always_ff @(posedge pClk)
    begin
        if (!rst_n)
        begin
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= issue_rd;
            // Each returned line goes straight back out as a write
            wr_valid <= c0_rsp.valid;
        end
    end

    // Addresses are line offsets from the programmed base
    always_ff @(posedge pClk)
    begin
        if (issue_rd)
            rd_addr <= cfg.src + {{(`AFU_ADDR_W-`AFU_CNT_W){1'b0}}, rd_idx};
        if (c0_rsp.valid)
        begin
            wr_addr <= cfg.dst + {{(`AFU_ADDR_W-`AFU_CNT_W){1'b0}}, wr_idx};
            wr_data <= c0_rsp.data;
        end
    end

    // Additive checksum over every line read, wrapping at the line width
    always_ff @(posedge pClk)
    begin
        if (!rst_n || start)
            sum_q <= '0;
        else if (c0_rsp.valid)
            sum_q <= sum_q + c0_rsp.data;
    end

    assign c0_req = '{valid: rd_valid, addr: rd_addr};
    assign c1_req = '{valid: wr_valid, addr: wr_addr, data: wr_data};
    assign sum    = sum_q;

endmodule

// File: rtl/afu_pkg.sv
`include "afu_macros.svh"

package afu_pkg;

    // ====================
    // Encodings
    // ====================

    // MMIO register indices, the values live with the other CSR constants
    typedef enum logic [`AFU_MMIO_IDX_W-1:0] {
        CSR_DFH    = `AFU_CSR_DFH,
        CSR_SRC    = `AFU_CSR_SRC,
        CSR_DST    = `AFU_CSR_DST,
        CSR_LEN    = `AFU_CSR_LEN,
        CSR_CTRL   = `AFU_CSR_CTRL,
        CSR_STATUS = `AFU_CSR_STATUS,
        CSR_SUM    = `AFU_CSR_SUM
    } csr_idx_e;

    // Copy sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } ctrl_state_e;

    // ====================
    // Host channels
    // ====================

    // One MMIO access per cycle, wr and rd are single-cycle strobes
    typedef struct packed {
        logic                  wr;
        logic                  rd;
        csr_idx_e              idx;
        logic [`AFU_LINE_W-1:0] data;
    } mmio_req_t;

    // Read data comes back exactly one cycle after the rd strobe
    typedef struct packed {
        logic                  valid;
        logic [`AFU_LINE_W-1:0] data;
    } mmio_rsp_t;

    // Line read request on c0
    typedef struct packed {
        logic                  valid;
        logic [`AFU_ADDR_W-1:0] addr;
    } rd_req_t;

    // Line read response, returned in request order
    typedef struct packed {
        logic                  valid;
        logic [`AFU_LINE_W-1:0] data;
    } rd_rsp_t;

    // Line write request on c1
    typedef struct packed {
        logic                  valid;
        logic [`AFU_ADDR_W-1:0] addr;
        logic [`AFU_LINE_W-1:0] data;
    } wr_req_t;

    // Copy job as programmed through the CSRs
    typedef struct packed {
        logic [`AFU_ADDR_W-1:0] src;
        logic [`AFU_ADDR_W-1:0] dst;
        logic [`AFU_CNT_W-1:0]  len;
    } copy_cfg_t;

endpackage

// File: rtl/afu_top.sv
`timescale 1ns/1ps
`include "afu_macros.svh"

module afu_top
(
    input  logic               pClk,
    input  logic               rst_n,
    input  afu_pkg::mmio_req_t mmio_in,
    output afu_pkg::mmio_rsp_t mmio_out,
    output afu_pkg::rd_req_t   c0_req,
    input  afu_pkg::rd_rsp_t   c0_rsp,
    input  logic               c0_almost_full,
    output afu_pkg::wr_req_t   c1_req,
    input  logic               c1_ack,
    output logic               done_irq
);

    import afu_pkg::*;

    // Job configuration shared by the counter and the datapath
    copy_cfg_t              cfg;
    logic                   start;
    logic                   busy;
    logic                   issue_rd;
    logic                   len_zero;
    logic                   all_issued;
    logic                   all_acked;
    logic [`AFU_CNT_W-1:0]  rd_idx;
    logic [`AFU_CNT_W-1:0]  wr_idx;
    logic [`AFU_LINE_W-1:0] sum;

    // ====================
    // Control
    // ====================

    // Software programs the job here and polls for completion
    afu_csr_regs csr_regs_i (
        .pClk     (pClk),
        .rst_n    (rst_n),
        .mmio_in  (mmio_in),
        .mmio_out (mmio_out),
        .busy     (busy),
        .done     (done_irq),
        .sum      (sum),
        .start    (start),
        .cfg      (cfg)
    );

    // The completion pulse doubles as the host interrupt
    afu_copy_ctrl copy_ctrl_i (
        .pClk           (pClk),
        .rst_n          (rst_n),
        .start          (start),
        .len_zero       (len_zero),
        .all_issued     (all_issued),
        .all_acked      (all_acked),
        .c0_almost_full (c0_almost_full),
        .issue_rd       (issue_rd),
        .busy           (busy),
        .done           (done_irq)
    );

    // ====================
    // Data movement
    // ====================

    afu_line_counter line_counter_i (
        .pClk         (pClk),
        .rst_n        (rst_n),
        .start        (start),
        .len          (cfg.len),
        .issue_rd     (issue_rd),
        .rd_rsp_valid (c0_rsp.valid),
        .wr_ack       (c1_ack),
        .rd_idx       (rd_idx),
        .wr_idx       (wr_idx),
        .all_issued   (all_issued),
        .all_acked    (all_acked),
        .len_zero     (len_zero)
    );

    afu_line_datapath line_datapath_i (
        .pClk     (pClk),
        .rst_n    (rst_n),
        .start    (start),
        .cfg      (cfg),
        .issue_rd (issue_rd),
        .rd_idx   (rd_idx),
        .wr_idx   (wr_idx),
        .c0_rsp   (c0_rsp),
        .c0_req   (c0_req),
        .c1_req   (c1_req),
        .sum      (sum)
    );

endmodule

// File: tb/afu_host_model.sv
`timescale 1ns/1ps
`include "afu_macros.svh"

module afu_host_model
#(
    parameter int MEM_LINES = 1024
)
(
    input  logic             pClk,
    input  logic             rst_n,
    input  logic             stress,
    input  afu_pkg::rd_req_t c0_req,
    output afu_pkg::rd_rsp_t c0_rsp,
    output logic             c0_almost_full,
    input  afu_pkg::wr_req_t c1_req,
    output logic             c1_ack
);

    import afu_pkg::*;

    // Host memory, one entry per line, loaded by the testbench
    logic [`AFU_LINE_W-1:0] mem [0:MEM_LINES-1];

    // Outstanding reads in request order, each with the cycle it may return in
    logic [`AFU_ADDR_W-1:0] rd_addr_q [$];
    int unsigned            rd_due_q [$];
    int unsigned            cyc = 0;
    int unsigned            last_due = 0;
    int unsigned            due;
    int unsigned            ack_pend = 0;
    logic                   ack_now;

    // Addresses wrap onto the modelled memory
    function automatic int unsigned line_index(input logic [`AFU_ADDR_W-1:0] addr);
        return addr % MEM_LINES;
    endfunction

    initial
    begin
        c0_rsp         = '0;
        c0_almost_full = 1'b0;
        c1_ack         = 1'b0;
    end

    always @(posedge pClk)
    begin
        if (!rst_n)
        begin
            c0_rsp         <= '0;
            c0_almost_full <= 1'b0;
            c1_ack         <= 1'b0;
            rd_addr_q.delete();
            rd_due_q.delete();
            cyc      = 0;
            last_due = 0;
            ack_pend = 0;
        end
        else
        begin
            cyc = cyc + 1;

            // ====================
            // Read channel
            // ====================

            // Only the oldest read may answer, which keeps responses in order
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc)
            begin
                c0_rsp <= '{valid: 1'b1, data: mem[line_index(rd_addr_q[0])]};
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
            else
                c0_rsp <= '{valid: 1'b0, data: '0};

            // Under stress the latency spreads over 1 to 8 cycles
            if (c0_req.valid)
            begin
                due = cyc + (stress ? 1 + $urandom % 8 : 2);
                // A later request never overtakes an earlier one
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                rd_addr_q.push_back(c0_req.addr);
                rd_due_q.push_back(due);
            end

            // Back-pressure is raised about one cycle in three when stressed
            c0_almost_full <= stress && ($urandom % 3 == 0);

            // ====================
            // Write channel
            // ====================

            // Acks for earlier writes only, so each lands in a later cycle
            ack_now = (ack_pend > 0) && (!stress || ($urandom % 2 == 0));
            c1_ack <= ack_now;
            if (ack_now)
                ack_pend = ack_pend - 1;
            if (c1_req.valid)
            begin
                mem[line_index(c1_req.addr)] = c1_req.data;
                ack_pend = ack_pend + 1;
            end
        end
    end

endmodule

// File: tb/afu_tb.sv
`timescale 1ns/1ps
`include "afu_macros.svh"

module afu_tb;

    import afu_pkg::*;

    localparam int          MEM_LINES   = 1024;
    // Random source data lives below this line, the fill pattern above it
    localparam int          RAND_LINES  = 256;
    // Four copies of 16 lines plus one empty copy
    localparam int          TOTAL_LINES = 64;
    localparam int          CYCLE_LIMIT = TOTAL_LINES * `AFU_TB_CYCLES_PER_LINE
                                          + `AFU_TB_TIMEOUT_BASE;
    localparam logic [31:0] SEED        = 32'ha5ba_359d;

    logic      pClk;
    logic      rst_n;
    logic      stress;
    mmio_req_t mmio_in;
    mmio_rsp_t mmio_out;
    rd_req_t   c0_req;
    rd_rsp_t   c0_rsp;
    logic      c0_almost_full;
    wr_req_t   c1_req;
    logic      c1_ack;
    logic      done_irq;

    // Memory contents as loaded, the source of truth for every copy
    logic [`AFU_LINE_W-1:0] img [0:MEM_LINES-1];

    int unsigned mismatch_cnt = 0;
    int unsigned fail_cnt = 0;
    int unsigned cycle_cnt = 0;
    int unsigned rd_req_cnt = 0;
    int unsigned wr_req_cnt = 0;
    int unsigned done_cnt = 0;
    int unsigned done_base = 0;
    logic        af_prev = 1'b0;

    afu_top afu_top_i (
        .pClk           (pClk),
        .rst_n          (rst_n),
        .mmio_in        (mmio_in),
        .mmio_out       (mmio_out),
        .c0_req         (c0_req),
        .c0_rsp         (c0_rsp),
        .c0_almost_full (c0_almost_full),
        .c1_req         (c1_req),
        .c1_ack         (c1_ack),
        .done_irq       (done_irq)
    );

    afu_host_model #(.MEM_LINES(MEM_LINES)) host_i (
        .pClk           (pClk),
        .rst_n          (rst_n),
        .stress         (stress),
        .c0_req         (c0_req),
        .c0_rsp         (c0_rsp),
        .c0_almost_full (c0_almost_full),
        .c1_req         (c1_req),
        .c1_ack         (c1_ack)
    );

    initial
        pClk = 1'b0;
    always #5 pClk = ~pClk;

    // ====================
    // Reference model
    // ====================

    // Background for lines that no copy reads, built from the full address
    function automatic logic [`AFU_LINE_W-1:0] fill_pattern(input logic [`AFU_ADDR_W-1:0] addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr};
    endfunction

    // Checksum is a plain sum of the source lines that wraps at 64 bits
    function automatic logic [`AFU_LINE_W-1:0] expected_sum(input logic [`AFU_ADDR_W-1:0] src,
                                                           input int unsigned len);
        logic [`AFU_LINE_W-1:0] acc;
        int unsigned            i;
        acc = '0;
        for (i = 0; i < len; i++)
            acc = acc + img[(src + i) % MEM_LINES];
        return acc;
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic check_line(input logic [`AFU_ADDR_W-1:0] addr,
                              input logic [`AFU_LINE_W-1:0] got,
                              input logic [`AFU_LINE_W-1:0] exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: line %h holds %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_mmio(input mmio_rsp_t got, input logic [`AFU_LINE_W-1:0] exp,
                              input string what);
        if (!got.valid)
        begin
            fail_cnt++;
            $display("No MMIO response one cycle after the %s read at time %0t", what, $time);
        end
        else if (got.data !== exp)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s read %h, expected %h", $time, what, got.data, exp);
        end
    endtask

    // ====================
    // MMIO access
    // ====================

    task automatic mmio_write(input csr_idx_e reg_idx, input logic [`AFU_LINE_W-1:0] value);
        @(posedge pClk);
        mmio_in <= '{wr: 1'b1, rd: 1'b0, idx: reg_idx, data: value};
        @(posedge pClk);
        mmio_in <= '{wr: 1'b0, rd: 1'b0, idx: reg_idx, data: '0};
    endtask

    // Samples the response exactly one cycle after the read strobe
    task automatic mmio_read(input csr_idx_e reg_idx, output mmio_rsp_t rsp);
        @(posedge pClk);
        mmio_in <= '{wr: 1'b0, rd: 1'b1, idx: reg_idx, data: '0};
        @(posedge pClk);
        mmio_in <= '{wr: 1'b0, rd: 1'b0, idx: reg_idx, data: '0};
        if (mmio_out.valid)
        begin
            fail_cnt++;
            $display("MMIO response for index %0d came early at time %0t", reg_idx, $time);
        end
        @(posedge pClk);
        rsp = mmio_out;
    endtask

    // ====================
    // Copy sequences
    // ====================

    task automatic start_copy(input logic [`AFU_ADDR_W-1:0] src,
                              input logic [`AFU_ADDR_W-1:0] dst,
                              input int unsigned len);
        mmio_write(CSR_SRC, src);
        mmio_write(CSR_DST, dst);
        mmio_write(CSR_LEN, len);
        done_base = done_cnt;
        mmio_write(CSR_CTRL, 64'h1);
    endtask

    // Waits for the completion pulse with a budget scaled to the job size
    task automatic wait_done(input int unsigned len);
        int unsigned waited;
        int unsigned budget;
        waited = 0;
        budget = len * `AFU_TB_CYCLES_PER_LINE + 200;
        while (done_cnt == done_base && waited < budget)
        begin
            @(posedge pClk);
            waited++;
        end
        if (done_cnt == done_base)
        begin
            fail_cnt++;
            $display("done_irq never arrived within %0d cycles, time %0t", budget, $time);
        end
    endtask

    task automatic check_copy(input logic [`AFU_ADDR_W-1:0] src,
                              input logic [`AFU_ADDR_W-1:0] dst,
                              input int unsigned len);
        mmio_rsp_t   rsp;
        int unsigned i;
        for (i = 0; i < len; i++)
            check_line(dst + i, host_i.mem[(dst + i) % MEM_LINES], img[(src + i) % MEM_LINES]);
        // Done set and busy clear once the sequencer is back in idle
        mmio_read(CSR_STATUS, rsp);
        check_mmio(rsp, 64'h2, "status");
        mmio_read(CSR_SUM, rsp);
        check_mmio(rsp, expected_sum(src, len), "checksum");
    endtask

    // ====================
    // Channel monitor
    // ====================

    // A request seen now was issued against the almost-full of the previous cycle
    always @(posedge pClk)
    begin
        if (rst_n)
        begin
            if (c0_req.valid)
            begin
                rd_req_cnt <= rd_req_cnt + 1;
                if (af_prev)
                begin
                    fail_cnt++;
                    $display("Read request issued while c0_almost_full was high, time %0t",
                             $time);
                end
            end
            if (c1_req.valid)
                wr_req_cnt <= wr_req_cnt + 1;
            if (done_irq)
                done_cnt <= done_cnt + 1;
        end
        af_prev <= c0_almost_full;
    end

    initial
    begin
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge pClk);
            cycle_cnt++;
        end
        fail_cnt++;
        $display("Timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        $display("Regression failed");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        mmio_rsp_t   rsp;
        int unsigned a;
        int unsigned rd_base;
        int unsigned wr_base;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        stress  = 1'b0;
        mmio_in = '0;
        for (a = 0; a < MEM_LINES; a++)
        begin
            img[a]       = (a < RAND_LINES) ? {$urandom, $urandom} : fill_pattern(a);
            host_i.mem[a] = img[a];
        end
        repeat (3) @(posedge pClk);
        rst_n <= 1'b1;
        @(posedge pClk);

        // Idle outputs, the DFH constant and a clear status after reset
        if (c0_req.valid || c1_req.valid || done_irq || mmio_out.valid)
        begin
            fail_cnt++;
            $display("Outputs not idle after reset at time %0t", $time);
        end
        mmio_read(CSR_DFH, rsp);
        check_mmio(rsp, `AFU_ID, "DFH");
        mmio_read(CSR_STATUS, rsp);
        check_mmio(rsp, '0, "status after reset");

        // Plain copy with fixed host latency
        start_copy(32'h040, 32'h100, 16);
        wait_done(16);
        check_copy(32'h040, 32'h100, 16);

        // Same again with random back-pressure, latency and ack timing
        stress <= 1'b1;
        start_copy(32'h060, 32'h140, 16);
        wait_done(16);
        stress <= 1'b0;
        check_copy(32'h060, 32'h140, 16);

        // Empty job must complete without touching either channel
        rd_base = rd_req_cnt;
        wr_base = wr_req_cnt;
        start_copy(32'h080, 32'h180, 0);
        wait_done(0);
        repeat (4) @(posedge pClk);
        if (rd_req_cnt != rd_base || wr_req_cnt != wr_base)
        begin
            mismatch_cnt++;
            $display("mismatch at %0t: empty copy issued %0d reads and %0d writes", $time,
                     rd_req_cnt - rd_base, wr_req_cnt - wr_base);
        end
        check_copy(32'h080, 32'h180, 0);

        // Source rewritten mid-run stays locked until the job finishes
        start_copy(32'h0a0, 32'h1c0, 16);
        repeat (4) @(posedge pClk);
        mmio_write(CSR_SRC, 64'h0c0);
        wait_done(16);
        check_copy(32'h0a0, 32'h1c0, 16);
        mmio_read(CSR_SRC, rsp);
        check_mmio(rsp, 64'h0a0, "source after locked write");
        start_copy(32'h0c0, 32'h200, 16);
        wait_done(16);
        check_copy(32'h0c0, 32'h200, 16);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/afu_pkg.sv
rtl/afu_csr_regs.sv
rtl/afu_copy_ctrl.sv
rtl/afu_line_counter.sv
rtl/afu_line_datapath.sv
rtl/afu_top.sv
tb/afu_host_model.sv
tb/afu_tb.sv
